//--- Makefile
TOP = tb_fetch_front

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

//--- rtl/bpu_config.sv
// ----------------------------------------------------------
// Prediction control register block
// Strobe write port, combinational read port
// ----------------------------------------------------------

`timescale 1ns/10ps

module bpu_config (
    input  wire logic                  core_clock_i,
    input  wire logic                  core_reset_i,
    input  wire logic                  cfg_we_i,
    input  wire logic [1:0]            cfg_addr_i,
    input  wire logic [31:0]           cfg_wdata_i,
    output      logic [31:0]           cfg_rdata_o,
    output      fetch_pkg::bpu_ctrl_t  ctrl_o
);

    localparam logic [1:0] ADDR_CTRL = 2'd0;

    fetch_pkg::bpu_ctrl_t ctrl_q;

    // Prediction on and overload off out of reset
    always_ff @(posedge core_clock_i) begin
        if (core_reset_i) begin
            ctrl_q.enable_pred     <= 1'b1;
            ctrl_q.enable_overload <= 1'b0;
            ctrl_q.overload_value  <= 1'b0;
        end else if (cfg_we_i && (cfg_addr_i == ADDR_CTRL)) begin
            ctrl_q.enable_pred     <= cfg_wdata_i[0];
            ctrl_q.enable_overload <= cfg_wdata_i[1];
            ctrl_q.overload_value  <= cfg_wdata_i[2];
        end
    end

    // Unmapped addresses read as zero
    always_comb begin
        cfg_rdata_o = 32'd0;
        if (cfg_addr_i == ADDR_CTRL) begin
            cfg_rdata_o[0] = ctrl_q.enable_pred;
            cfg_rdata_o[1] = ctrl_q.enable_overload;
            cfg_rdata_o[2] = ctrl_q.overload_value;
        end
    end

    assign ctrl_o = ctrl_q;

endmodule

//--- rtl/btb.sv
// ----------------------------------------------------------
// Two-way branch target buffer
// Combinational lookup, commit-side fill and counter
// training, invalidation on correct, toggling replacement
// ----------------------------------------------------------

`timescale 1ns/10ps

module btb #(
    parameter int ENTRIES = 128
) (
    input  wire logic                                  core_clock_i,
    input  wire logic                                  core_reset_i,
    input  wire logic [fetch_pkg::PC_BITS-1:0]         lookup_pc_i,
    input  wire fetch_pkg::bpu_ctrl_t                  ctrl_i,
    output      fetch_pkg::btb_lookup_t                lookup_o,
    input  wire fetch_pkg::btb_update_t                update_i,
    input  wire logic                                  correct_i,
    input  wire logic [fetch_pkg::PC_BITS-1:0]         correct_pc_i
);

    localparam int SETS     = ENTRIES / 2;
    localparam int IDX_BITS = $clog2(SETS);
    localparam int TAG_BITS = fetch_pkg::PC_BITS - IDX_BITS;

    logic [SETS-1:0]                   valid_q   [2];
    logic [TAG_BITS-1:0]               tag_q     [2][SETS];
    logic [fetch_pkg::PC_BITS-1:0]     target_q  [2][SETS];
    fetch_pkg::br_type_e               btype_q   [2][SETS];
    logic [1:0]                        counter_q [2][SETS];
    logic                              repl_q;

    // Lookup side
    logic [IDX_BITS-1:0] lk_idx;
    logic [TAG_BITS-1:0] lk_tag;
    logic [1:0]          lk_match;
    logic                lk_way;

    assign lk_idx = lookup_pc_i[IDX_BITS-1:0];
    assign lk_tag = lookup_pc_i[fetch_pkg::PC_BITS-1:IDX_BITS];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            lk_match[w] = valid_q[w][lk_idx] && (tag_q[w][lk_idx] == lk_tag);
        end
    end

    // Full tags, so at most one way matches
    assign lk_way = lk_match[1];

    always_comb begin
        lookup_o.hit    = |lk_match;
        lookup_o.way    = lk_way;
        lookup_o.btype  = btype_q[lk_way][lk_idx];
        lookup_o.target = target_q[lk_way][lk_idx];
        if (ctrl_i.enable_overload) begin
            lookup_o.counter = {ctrl_i.overload_value, ctrl_i.overload_value};
        end else begin
            lookup_o.counter = counter_q[lk_way][lk_idx];
        end
    end

    // Write side, a modify takes the port ahead of a correct
    logic [fetch_pkg::PC_BITS-1:0] wr_pc;
    logic [IDX_BITS-1:0]           wr_idx;
    logic [TAG_BITS-1:0]           wr_tag;
    logic [1:0]                    wr_match;
    logic                          both_valid;
    logic                          fill_way;
    logic [IDX_BITS-1:0]           bm_idx;
    logic [1:0]                    new_cntr;

    assign wr_pc  = update_i.modify ? update_i.vpc : correct_pc_i;
    assign wr_idx = wr_pc[IDX_BITS-1:0];
    assign wr_tag = wr_pc[fetch_pkg::PC_BITS-1:IDX_BITS];
    assign bm_idx = update_i.vpc[IDX_BITS-1:0];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            wr_match[w] = valid_q[w][wr_idx] && (tag_q[w][wr_idx] == wr_tag);
        end
    end

    assign both_valid = valid_q[0][wr_idx] && valid_q[1][wr_idx];

    // Matching way first, then an empty way (way 0 first), then the toggle
    always_comb begin
        if (|wr_match) begin
            fill_way = wr_match[1];
        end else if (both_valid) begin
            fill_way = repl_q;
        end else begin
            fill_way = valid_q[0][wr_idx];
        end
    end

    // Saturating step of the counter seen at prediction time
    always_comb begin
        if (update_i.taken) begin
            new_cntr = (update_i.cntr_pred == 2'b11) ? 2'b11 : update_i.cntr_pred + 2'd1;
        end else begin
            new_cntr = (update_i.cntr_pred == 2'b00) ? 2'b00 : update_i.cntr_pred - 2'd1;
        end
    end

    always_ff @(posedge core_clock_i) begin
        if (update_i.modify) begin
            tag_q[fill_way][wr_idx]     <= wr_tag;
            target_q[fill_way][wr_idx]  <= update_i.target;
            btype_q[fill_way][wr_idx]   <= update_i.btype;
            counter_q[fill_way][wr_idx] <= new_cntr;
        end else if (update_i.bm_only) begin
            counter_q[update_i.way][bm_idx] <= new_cntr;
        end
    end

    always_ff @(posedge core_clock_i) begin
        if (core_reset_i) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
            repl_q     <= 1'b0;
        end else if (update_i.modify) begin
            valid_q[fill_way][wr_idx] <= 1'b1;
            if (!(|wr_match) && both_valid) begin
                repl_q <= ~repl_q;
            end
        end else if (correct_i) begin
            for (int w = 0; w < 2; w++) begin
                if (wr_match[w]) begin
                    valid_q[w][wr_idx] <= 1'b0;
                end
            end
        end
    end

    // Commit side sends one kind of update per cycle
    a_single_update: assert property (
        @(posedge core_clock_i) disable iff (core_reset_i)
        !(update_i.modify && update_i.bm_only)
    );

endmodule

//--- rtl/fetch_front_top.sv
// ----------------------------------------------------------
// Fetch-address front end top level
// Connects the config block, BTB, RAS and PC generator
// ----------------------------------------------------------

`timescale 1ns/10ps

module fetch_front_top #(
    parameter logic [fetch_pkg::PC_BITS-1:0] START_PC    = '0,
    parameter int                            BTB_ENTRIES = 128,
    parameter int                            RAS_DEPTH   = 8
) (
    input  wire logic                              core_clock_i,
    input  wire logic                              core_reset_i,
    input  wire logic                              core_flush_i,
    input  wire logic [fetch_pkg::PC_BITS-1:0]     flush_pc_i,
    input  wire logic                              tlb_busy_i,
    input  wire logic                              correct_i,
    input  wire logic [fetch_pkg::PC_BITS-1:0]     correct_pc_i,
    input  wire fetch_pkg::btb_update_t            update_i,
    input  wire logic                              call_affirm_i,
    input  wire logic                              ret_affirm_i,
    input  wire logic                              cfg_we_i,
    input  wire logic [1:0]                        cfg_addr_i,
    input  wire logic [31:0]                       cfg_wdata_i,
    output      logic [31:0]                       cfg_rdata_o,
    output      logic                              fetch_valid_o,
    output      fetch_pkg::fetch_out_t             fetch_o
);

    fetch_pkg::bpu_ctrl_t          ctrl;
    fetch_pkg::btb_lookup_t        lookup;
    logic [fetch_pkg::PC_BITS-1:0] pc;
    logic [fetch_pkg::PC_BITS-1:0] ras_top;
    logic [fetch_pkg::PC_BITS-1:0] push_addr;
    logic                          push;
    logic                          pop;

    bpu_config u_bpu_config (
        .core_clock_i (core_clock_i),
        .core_reset_i (core_reset_i),
        .cfg_we_i     (cfg_we_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_wdata_i  (cfg_wdata_i),
        .cfg_rdata_o  (cfg_rdata_o),
        .ctrl_o       (ctrl)
    );

    btb #(
        .ENTRIES (BTB_ENTRIES)
    ) u_btb (
        .core_clock_i (core_clock_i),
        .core_reset_i (core_reset_i),
        .lookup_pc_i  (pc),
        .ctrl_i       (ctrl),
        .lookup_o     (lookup),
        .update_i     (update_i),
        .correct_i    (correct_i),
        .correct_pc_i (correct_pc_i)
    );

    ras #(
        .DEPTH (RAS_DEPTH)
    ) u_ras (
        .core_clock_i  (core_clock_i),
        .core_reset_i  (core_reset_i),
        .push_i        (push),
        .pop_i         (pop),
        .push_addr_i   (push_addr),
        .update_i      (update_i),
        .call_affirm_i (call_affirm_i),
        .ret_affirm_i  (ret_affirm_i),
        .top_o         (ras_top)
    );

    pc_gen #(
        .START_PC (START_PC)
    ) u_pc_gen (
        .core_clock_i  (core_clock_i),
        .core_reset_i  (core_reset_i),
        .core_flush_i  (core_flush_i),
        .flush_pc_i    (flush_pc_i),
        .tlb_busy_i    (tlb_busy_i),
        .ctrl_i        (ctrl),
        .lookup_i      (lookup),
        .ras_top_i     (ras_top),
        .pc_o          (pc),
        .push_o        (push),
        .pop_o         (pop),
        .push_addr_o   (push_addr),
        .fetch_valid_o (fetch_valid_o),
        .fetch_o       (fetch_o)
    );

endmodule

//--- rtl/fetch_pkg.sv
// ----------------------------------------------------------
// Shared definitions for the fetch-address front end
// Word address width, branch type encoding, control bits
// and the packed records passed between the blocks
// ----------------------------------------------------------

package fetch_pkg;

    // Word fetch address, no compressed instructions
    localparam int PC_BITS = 30;

    typedef enum logic [1:0] {
        BR_COND = 2'd0,
        BR_CALL = 2'd1,
        BR_JUMP = 2'd2,
        BR_RET  = 2'd3
    } br_type_e;

    // Bit 0 is enable_pred when read as a register word
    typedef struct packed {
        logic overload_value;
        logic enable_overload;
        logic enable_pred;
    } bpu_ctrl_t;

    // Commit-side update record
    typedef struct packed {
        logic               modify;
        logic               bm_only;
        logic [PC_BITS-1:0] vpc;
        logic [PC_BITS-1:0] target;
        logic [1:0]         cntr_pred;
        logic               taken;
        br_type_e           btype;
        logic               way;
    } btb_update_t;

    // Combinational lookup result
    typedef struct packed {
        logic               hit;
        logic               way;
        br_type_e           btype;
        logic [1:0]         counter;
        logic [PC_BITS-1:0] target;
    } btb_lookup_t;

    // Registered record for the translation stage
    typedef struct packed {
        logic [PC_BITS-1:0] pc;
        br_type_e           btype;
        logic [1:0]         bm_pred;
        logic [PC_BITS-1:0] target;
        logic               hit;
        logic               way;
    } fetch_out_t;

endpackage

//--- rtl/pc_gen.sv
// ----------------------------------------------------------
// Program counter and next-address selection
// Redirect on predicted branches, RAS strobes and the
// registered output to the translation stage
// ----------------------------------------------------------

`timescale 1ns/10ps

module pc_gen #(
    parameter logic [fetch_pkg::PC_BITS-1:0] START_PC = '0
) (
    input  wire logic                              core_clock_i,
    input  wire logic                              core_reset_i,
    input  wire logic                              core_flush_i,
    input  wire logic [fetch_pkg::PC_BITS-1:0]     flush_pc_i,
    input  wire logic                              tlb_busy_i,
    input  wire fetch_pkg::bpu_ctrl_t              ctrl_i,
    input  wire fetch_pkg::btb_lookup_t            lookup_i,
    input  wire logic [fetch_pkg::PC_BITS-1:0]     ras_top_i,
    output      logic [fetch_pkg::PC_BITS-1:0]     pc_o,
    output      logic                              push_o,
    output      logic                              pop_o,
    output      logic [fetch_pkg::PC_BITS-1:0]     push_addr_o,
    output      logic                              fetch_valid_o,
    output      fetch_pkg::fetch_out_t             fetch_o
);

    logic [fetch_pkg::PC_BITS-1:0] pc_q;
    logic [fetch_pkg::PC_BITS-1:0] pc_inc;
    logic [fetch_pkg::PC_BITS-1:0] final_target;
    logic [fetch_pkg::PC_BITS-1:0] next_pc;
    logic                          pred_hit;
    logic                          redirect;
    logic                          advance;

    assign pc_inc = pc_q + 1'b1;

    // Returns take their target from the stack
    assign final_target = (lookup_i.btype == fetch_pkg::BR_RET) ? ras_top_i : lookup_i.target;

    assign pred_hit = lookup_i.hit && ctrl_i.enable_pred;
    assign redirect = pred_hit &&
                      ((lookup_i.btype != fetch_pkg::BR_COND) || lookup_i.counter[1]);
    assign next_pc  = redirect ? final_target : pc_inc;

    // Fetch slot is consumed this cycle
    assign advance = !core_reset_i && !core_flush_i && !tlb_busy_i;

    assign push_o      = advance && pred_hit && (lookup_i.btype == fetch_pkg::BR_CALL);
    assign pop_o       = advance && pred_hit && (lookup_i.btype == fetch_pkg::BR_RET);
    assign push_addr_o = pc_inc;

    always_ff @(posedge core_clock_i) begin
        if (core_reset_i) begin
            pc_q          <= START_PC;
            fetch_valid_o <= 1'b0;
        end else if (core_flush_i) begin
            pc_q          <= flush_pc_i;
            fetch_valid_o <= 1'b0;
        end else if (!tlb_busy_i) begin
            pc_q          <= next_pc;
            fetch_valid_o <= 1'b1;
        end
    end

    // Payload holds while the next stage is busy
    always_ff @(posedge core_clock_i) begin
        if (advance) begin
            fetch_o.pc      <= pc_q;
            fetch_o.btype   <= lookup_i.btype;
            fetch_o.bm_pred <= lookup_i.counter;
            fetch_o.target  <= final_target;
            fetch_o.hit     <= pred_hit;
            fetch_o.way     <= lookup_i.way;
        end
    end

    assign pc_o = pc_q;

    // A flush leaves one empty output slot before the flush target appears
    a_valid_gap: assert property (
        @(posedge core_clock_i) disable iff (core_reset_i)
        ($past(core_flush_i) && !$past(core_reset_i) && !core_flush_i && !tlb_busy_i)
            |=> !$past(fetch_valid_o) && fetch_valid_o
                && (fetch_o.pc == $past(flush_pc_i, 2))
    );

endmodule

//--- rtl/ras.sv
// ----------------------------------------------------------
// Return address stack
// Speculative pointer for predicted calls and returns,
// real pointer for committed ones, repair on misprediction
// ----------------------------------------------------------

`timescale 1ns/10ps

module ras #(
    parameter int DEPTH = 8
) (
    input  wire logic                              core_clock_i,
    input  wire logic                              core_reset_i,
    input  wire logic                              push_i,
    input  wire logic                              pop_i,
    input  wire logic [fetch_pkg::PC_BITS-1:0]     push_addr_i,
    input  wire fetch_pkg::btb_update_t            update_i,
    input  wire logic                              call_affirm_i,
    input  wire logic                              ret_affirm_i,
    output      logic [fetch_pkg::PC_BITS-1:0]     top_o
);

    localparam int PTR_BITS = $clog2(DEPTH);

    logic [fetch_pkg::PC_BITS-1:0] stack_q [DEPTH];
    logic [PTR_BITS-1:0]           spec_q;
    logic [PTR_BITS-1:0]           real_q;

    logic                call_fix;
    logic                ret_fix;
    logic [PTR_BITS-1:0] spec_p1;
    logic [PTR_BITS-1:0] spec_m1;
    logic [PTR_BITS-1:0] real_p1;
    logic [PTR_BITS-1:0] real_m1;

    // A modify of call or ret type means the speculative state is wrong
    assign call_fix = update_i.modify && (update_i.btype == fetch_pkg::BR_CALL);
    assign ret_fix  = update_i.modify && (update_i.btype == fetch_pkg::BR_RET);

    // Pointers wrap around the stack
    assign spec_p1 = spec_q + 1'b1;
    assign spec_m1 = spec_q - 1'b1;
    assign real_p1 = real_q + 1'b1;
    assign real_m1 = real_q - 1'b1;

    always_ff @(posedge core_clock_i) begin
        if (call_fix) begin
            stack_q[real_p1] <= update_i.vpc + 1'b1;
        end else if (!ret_fix && push_i) begin
            stack_q[spec_p1] <= push_addr_i;
        end
    end

    always_ff @(posedge core_clock_i) begin
        if (core_reset_i) begin
            spec_q <= '0;
        end else if (call_fix) begin
            spec_q <= real_p1;
        end else if (ret_fix) begin
            spec_q <= real_m1;
        end else if (push_i) begin
            spec_q <= spec_p1;
        end else if (pop_i) begin
            spec_q <= spec_m1;
        end
    end

    always_ff @(posedge core_clock_i) begin
        if (core_reset_i) begin
            real_q <= '0;
        end else if (call_fix || call_affirm_i) begin
            real_q <= real_p1;
        end else if (ret_fix || ret_affirm_i) begin
            real_q <= real_m1;
        end
    end

    assign top_o = stack_q[spec_q];

    // One fetch slot is never both a call and a return
    a_push_pop: assert property (
        @(posedge core_clock_i) disable iff (core_reset_i)
        !(push_i && pop_i)
    );

endmodule

//--- sources.f
rtl/fetch_pkg.sv
rtl/bpu_config.sv
rtl/btb.sv
rtl/ras.sv
rtl/pc_gen.sv
rtl/fetch_front_top.sv
test/tb_fetch_front.sv

//--- test/tb_fetch_front.sv
// ----------------------------------------------------------
// Testbench for the fetch-address front end
// Clock, reset, stimulus tasks, reference prediction model,
// per-cycle output checker and cycle limit
// ----------------------------------------------------------

`timescale 1ns/10ps

module tb_fetch_front;

    localparam logic [29:0] START_PC   = 30'h100;
    localparam int          MAX_CYCLES = 2000;

    logic                   core_clock_i;
    logic                   core_reset_i;
    logic                   core_flush_i;
    logic [29:0]            flush_pc_i;
    logic                   tlb_busy_i;
    logic                   correct_i;
    logic [29:0]            correct_pc_i;
    fetch_pkg::btb_update_t update_i;
    logic                   call_affirm_i;
    logic                   ret_affirm_i;
    logic                   cfg_we_i;
    logic [1:0]             cfg_addr_i;
    logic [31:0]            cfg_wdata_i;
    logic [31:0]            cfg_rdata_o;
    logic                   fetch_valid_o;
    fetch_pkg::fetch_out_t  fetch_o;

    // Reference model state for 8 sets of 2 ways and a 4-deep stack
    logic                 m_valid [2][8];
    logic [29:0]          m_pc    [2][8];
    logic [29:0]          m_tgt   [2][8];
    fetch_pkg::br_type_e  m_type  [2][8];
    logic [1:0]           m_cnt   [2][8];
    logic                 m_repl;
    fetch_pkg::bpu_ctrl_t m_ctrl;
    logic [29:0]          m_stack [4];
    logic [1:0]           m_spec;
    logic [1:0]           m_real;

    // Checker state
    logic [29:0]           exp_pc;
    logic                  exp_valid;
    logic                  exp_raw;
    fetch_pkg::fetch_out_t exp_out;
    int                    cycles;

    fetch_front_top #(
        .START_PC    (START_PC),
        .BTB_ENTRIES (16),
        .RAS_DEPTH   (4)
    ) dut (
        .core_clock_i  (core_clock_i),
        .core_reset_i  (core_reset_i),
        .core_flush_i  (core_flush_i),
        .flush_pc_i    (flush_pc_i),
        .tlb_busy_i    (tlb_busy_i),
        .correct_i     (correct_i),
        .correct_pc_i  (correct_pc_i),
        .update_i      (update_i),
        .call_affirm_i (call_affirm_i),
        .ret_affirm_i  (ret_affirm_i),
        .cfg_we_i      (cfg_we_i),
        .cfg_addr_i    (cfg_addr_i),
        .cfg_wdata_i   (cfg_wdata_i),
        .cfg_rdata_o   (cfg_rdata_o),
        .fetch_valid_o (fetch_valid_o),
        .fetch_o       (fetch_o)
    );

    initial core_clock_i = 1'b0;
    always #5 core_clock_i = ~core_clock_i;

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    function automatic logic [1:0] step(input logic [1:0] c, input logic tk);
        if (tk) begin
            return (c == 2'b11) ? c : c + 2'd1;
        end
        return (c == 2'b00) ? c : c - 2'd1;
    endfunction

    function automatic int find_way(input logic [29:0] pc);
        for (int w = 0; w < 2; w++) begin
            if (m_valid[w][pc[2:0]] && (m_pc[w][pc[2:0]] == pc)) begin
                return w;
            end
        end
        return -1;
    endfunction

    // Expected fetch record for pc and the pc that follows it
    function automatic fetch_pkg::fetch_out_t predict(input logic [29:0] pc,
                                                      output logic [29:0] nxt,
                                                      output logic raw);
        fetch_pkg::fetch_out_t r;
        int                    w;
        logic [2:0]            idx;
        logic                  redir;
        r   = '0;
        raw = 1'b0;
        idx = pc[2:0];
        w   = find_way(pc);
        r.pc = pc;
        if (w >= 0) begin
            raw       = 1'b1;
            r.way     = (w == 1);
            r.btype   = m_type[w][idx];
            r.bm_pred = m_ctrl.enable_overload ?
                        {m_ctrl.overload_value, m_ctrl.overload_value} : m_cnt[w][idx];
            r.target  = (r.btype == fetch_pkg::BR_RET) ? m_stack[m_spec] : m_tgt[w][idx];
        end
        r.hit = raw && m_ctrl.enable_pred;
        redir = r.hit && ((r.btype != fetch_pkg::BR_COND) || r.bm_pred[1]);
        nxt   = redir ? r.target : pc + 30'd1;
        return r;
    endfunction

    // Compare process samples inputs at the rising edge where they are stable
    always @(posedge core_clock_i) begin
        logic [29:0] nxt;
        if (core_reset_i) begin
            exp_pc    = START_PC;
            exp_valid = 1'b0;
        end else if (core_flush_i) begin
            exp_pc    = flush_pc_i;
            exp_valid = 1'b0;
        end else if (!tlb_busy_i) begin
            exp_out = predict(exp_pc, nxt, exp_raw);
            if (exp_out.hit && (exp_out.btype == fetch_pkg::BR_CALL)) begin
                m_spec          = m_spec + 2'd1;
                m_stack[m_spec] = exp_pc + 30'd1;
            end else if (exp_out.hit && (exp_out.btype == fetch_pkg::BR_RET)) begin
                m_spec = m_spec - 2'd1;
            end
            exp_pc    = nxt;
            exp_valid = 1'b1;
        end
        #1;
        check("fetch_valid_o", 64'(fetch_valid_o), 64'(exp_valid));
        if (exp_valid) begin
            check("fetch_o.pc", 64'(fetch_o.pc), 64'(exp_out.pc));
            check("fetch_o.hit", 64'(fetch_o.hit), 64'(exp_out.hit));
            if (exp_raw) begin
                check("fetch_o.btype", 64'(fetch_o.btype), 64'(exp_out.btype));
                check("fetch_o.bm_pred", 64'(fetch_o.bm_pred), 64'(exp_out.bm_pred));
                check("fetch_o.target", 64'(fetch_o.target), 64'(exp_out.target));
                check("fetch_o.way", 64'(fetch_o.way), 64'(exp_out.way));
            end
        end
    end

    always @(posedge core_clock_i) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run went past %0d cycles", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

    task automatic run(input int n, input logic rand_busy);
        repeat (n) begin
            @(negedge core_clock_i);
            tlb_busy_i = rand_busy ? ($urandom_range(3) == 0) : 1'b0;
        end
        @(negedge core_clock_i);
        tlb_busy_i = 1'b0;
    endtask

    task automatic flush_to(input logic [29:0] pc);
        @(negedge core_clock_i);
        core_flush_i = 1'b1;
        flush_pc_i   = pc;
        tlb_busy_i   = 1'b0;
        @(negedge core_clock_i);
        core_flush_i = 1'b0;
    endtask

    // Commit-side update sent while fetch is held
    task automatic post_update(input logic mod, input logic bm, input logic [29:0] vpc,
                               input logic [29:0] tgt, input logic [1:0] cp, input logic tk,
                               input fetch_pkg::br_type_e bt, input logic wy);
        int         w;
        logic [2:0] idx;
        idx = vpc[2:0];
        @(negedge core_clock_i);
        tlb_busy_i         = 1'b1;
        update_i.modify    = mod;
        update_i.bm_only   = bm;
        update_i.vpc       = vpc;
        update_i.target    = tgt;
        update_i.cntr_pred = cp;
        update_i.taken     = tk;
        update_i.btype     = bt;
        update_i.way       = wy;
        if (mod) begin
            w = find_way(vpc);
            if (w < 0) begin
                if (!m_valid[0][idx]) begin
                    w = 0;
                end else if (!m_valid[1][idx]) begin
                    w = 1;
                end else begin
                    w      = m_repl ? 1 : 0;
                    m_repl = ~m_repl;
                end
            end
            m_valid[w][idx] = 1'b1;
            m_pc[w][idx]    = vpc;
            m_tgt[w][idx]   = tgt;
            m_type[w][idx]  = bt;
            m_cnt[w][idx]   = step(cp, tk);
            if (bt == fetch_pkg::BR_CALL) begin
                m_real          = m_real + 2'd1;
                m_spec          = m_real;
                m_stack[m_real] = vpc + 30'd1;
            end else if (bt == fetch_pkg::BR_RET) begin
                m_real = m_real - 2'd1;
                m_spec = m_real;
            end
        end else if (bm) begin
            m_cnt[wy][idx] = step(cp, tk);
        end
        @(negedge core_clock_i);
        update_i   = '0;
        tlb_busy_i = 1'b0;
    endtask

    task automatic pulse_correct(input logic [29:0] pc);
        int w;
        @(negedge core_clock_i);
        tlb_busy_i   = 1'b1;
        correct_i    = 1'b1;
        correct_pc_i = pc;
        w = find_way(pc);
        if (w >= 0) begin
            m_valid[w][pc[2:0]] = 1'b0;
        end
        @(negedge core_clock_i);
        correct_i  = 1'b0;
        tlb_busy_i = 1'b0;
    endtask

    task automatic affirm(input logic is_call);
        @(negedge core_clock_i);
        tlb_busy_i    = 1'b1;
        call_affirm_i = is_call;
        ret_affirm_i  = !is_call;
        m_real = is_call ? m_real + 2'd1 : m_real - 2'd1;
        @(negedge core_clock_i);
        call_affirm_i = 1'b0;
        ret_affirm_i  = 1'b0;
        tlb_busy_i    = 1'b0;
    endtask

    task automatic cfg_write(input logic [1:0] addr, input logic [31:0] data);
        @(negedge core_clock_i);
        tlb_busy_i  = 1'b1;
        cfg_we_i    = 1'b1;
        cfg_addr_i  = addr;
        cfg_wdata_i = data;
        if (addr == 2'd0) begin
            m_ctrl = data[2:0];
        end
        @(negedge core_clock_i);
        cfg_we_i   = 1'b0;
        tlb_busy_i = 1'b0;
        check("cfg_rdata_o", 64'(cfg_rdata_o), (addr == 2'd0) ? 64'(data[2:0]) : 64'd0);
        cfg_addr_i = 2'd0;
    endtask

    initial begin
        logic [29:0] pcs [3];
        logic [26:0] tag;
        logic        dup;
        void'($urandom(16095));
        cycles        = 0;
        core_reset_i  = 1'b1;
        core_flush_i  = 1'b0;
        flush_pc_i    = '0;
        tlb_busy_i    = 1'b0;
        correct_i     = 1'b0;
        correct_pc_i  = '0;
        update_i      = '0;
        call_affirm_i = 1'b0;
        ret_affirm_i  = 1'b0;
        cfg_we_i      = 1'b0;
        cfg_addr_i    = 2'd0;
        cfg_wdata_i   = '0;
        m_valid       = '{default: '0};
        m_repl        = 1'b0;
        m_ctrl        = 3'b001;
        m_stack       = '{default: '0};
        m_spec        = 2'd0;
        m_real        = 2'd0;
        repeat (4) @(negedge core_clock_i);
        core_reset_i = 1'b0;
        while (!fetch_valid_o) @(negedge core_clock_i);

        // Sequential fetch with random back-pressure
        run(40, 1'b1);

        // Conditional branch, then trained down to not taken
        post_update(1'b1, 1'b0, 30'h120, 30'h200, 2'd1, 1'b1, fetch_pkg::BR_COND, 1'b0);
        flush_to(30'h11E);
        run(10, 1'b1);
        post_update(1'b0, 1'b1, 30'h120, 30'h0, 2'd2, 1'b0, fetch_pkg::BR_COND,
                    find_way(30'h120) == 1);
        flush_to(30'h11E);
        run(8, 1'b0);

        // Call and return, then RAS repair from a committed call
        post_update(1'b1, 1'b0, 30'h302, 30'h0, 2'd0, 1'b1, fetch_pkg::BR_RET, 1'b0);
        post_update(1'b1, 1'b0, 30'h140, 30'h300, 2'd0, 1'b1, fetch_pkg::BR_CALL, 1'b0);
        flush_to(30'h13F);
        run(12, 1'b1);
        post_update(1'b1, 1'b0, 30'h180, 30'h300, 2'd0, 1'b1, fetch_pkg::BR_CALL, 1'b0);
        flush_to(30'h300);
        run(8, 1'b0);
        affirm(1'b1);
        affirm(1'b0);

        // Correct drops the installed call entry and the flush resumes just before it
        pulse_correct(30'h180);
        flush_to(30'h17F);
        run(6, 1'b1);

        // Configuration
        cfg_write(2'd0, 32'h0);
        flush_to(30'h13F);
        run(6, 1'b0);
        cfg_write(2'd0, 32'h7);
        flush_to(30'h13F);
        run(6, 1'b0);
        cfg_write(2'd0, 32'h3);
        flush_to(30'h13F);
        run(6, 1'b0);
        cfg_write(2'd2, 32'hFFFF_FFFF);
        cfg_write(2'd0, 32'h1);

        // Replacement in set 5 with random tags
        for (int k = 0; k < 3; k++) begin
            dup = 1'b1;
            while (dup) begin
                tag    = 27'($urandom);
                pcs[k] = {tag, 3'd5};
                dup    = 1'b0;
                for (int j = 0; j < k; j++) begin
                    if (pcs[j] == pcs[k]) begin
                        dup = 1'b1;
                    end
                end
            end
        end
        post_update(1'b1, 1'b0, pcs[0], 30'h400, 2'd1, 1'b1, fetch_pkg::BR_JUMP, 1'b0);
        post_update(1'b1, 1'b0, pcs[1], 30'h401, 2'd1, 1'b1, fetch_pkg::BR_JUMP, 1'b0);
        for (int k = 0; k < 2; k++) begin
            flush_to(pcs[k]);
            run(4, 1'b0);
        end
        post_update(1'b1, 1'b0, pcs[2], 30'h402, 2'd1, 1'b1, fetch_pkg::BR_JUMP, 1'b0);
        for (int k = 0; k < 3; k++) begin
            flush_to(pcs[k]);
            run(4, 1'b1);
        end

        run(4, 1'b0);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
